/* build.f */
logic/lut_pkg.sv
logic/lut_decoder.sv
logic/lut_result_unpack.sv
logic/lut_wb_slave.sv
logic/lut_top.sv
tests/lut_tb.sv

/* Makefile */
# Verilator build, run, lint and clean

VERILATOR  ?= verilator
TOP        ?= lut_tb
RTL_TOP    ?= lut_top
FILELIST   ?= build.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter logic/%,$(SRCS))
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "test passed" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/lut_tb.sv */
// Lookup subsystem testbench
`timescale 1ns/10ps

module lut_tb;

   // --------------------------------------------------
   // Run length
   // --------------------------------------------------
   localparam int RST_CYCLES = 16;
   // Bus accesses of all tests, rounded up
   localparam int N_TRANS = 200;
   localparam int N_RAND = 20;

   logic        clk = 1'b0;
   logic        rst = 1'b1;
   logic        cyc = 1'b0;
   logic        stb = 1'b0;
   logic        we = 1'b0;
   logic [2:0]  adr = '0;
   logic [31:0] dat_w = '0;
   logic [31:0] dat_r;
   logic        ack;

   // Expected read data, armed for one access
   logic        chk_on = 1'b0;
   logic [31:0] chk_exp = '0;
   string       chk_name = "";
   // Data of the last access
   logic [31:0] rd_val;
   int          seed = 9;

   lut_top u_dut (
      .clk   (clk),
      .rst   (rst),
      .cyc   (cyc),
      .stb   (stb),
      .we    (we),
      .adr   (adr),
      .dat_w (dat_w),
      .dat_r (dat_r),
      .ack   (ack)
   );

   initial begin
      forever #2 clk = ~clk;
   end

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("test failed");
      $fatal(1);
   endtask

   // Watchdog
   initial begin
      repeat (RST_CYCLES + N_TRANS * 20) @(posedge clk);
      stop_on_error("Timeout, the bus tests did not finish in time");
   end

   // --------------------------------------------------
   // Reference model
   // --------------------------------------------------
   // X(i) = i*4096 + i*341 on 24 bits
   function automatic logic [23:0] x_of(input int i);
      return 24'((i << 12) + i * 341);
   endfunction

   // u(i) = i*291 on 16 bits
   function automatic logic [15:0] u_of(input int i);
      return 16'(i * 291);
   endfunction

   // --------------------------------------------------
   // Bus driver
   // --------------------------------------------------
   // Strobe held until ack, read data taken in the ack cycle
   task automatic bus_access(input logic wr, input logic [2:0] a, input logic [31:0] d,
                             input logic arm, input logic [31:0] exp, input string name);
      @(posedge clk);
      cyc      <= 1'b1;
      stb      <= 1'b1;
      we       <= wr;
      adr      <= a;
      dat_w    <= d;
      chk_on   <= arm;
      chk_exp  <= exp;
      chk_name = name;
      do begin
         @(posedge clk);
      end while (!ack);
      rd_val = dat_r;
      cyc    <= 1'b0;
      stb    <= 1'b0;
      we     <= 1'b0;
      chk_on <= 1'b0;
   endtask

   task automatic write_reg(input logic [2:0] a, input logic [31:0] d);
      bus_access(1'b1, a, d, 1'b0, 32'h0, "");
   endtask

   // Read with an armed data check
   task automatic check_reg(input logic [2:0] a, input logic [31:0] exp, input string name);
      bus_access(1'b0, a, 32'h0, 1'b1, exp, name);
   endtask

   // Status poll until the lookup lands
   task automatic wait_ready();
      do begin
         bus_access(1'b0, lut_pkg::ADDR_STATUS, 32'h0, 1'b0, 32'h0, "");
      end while (!rd_val[0]);
   endtask

   // --------------------------------------------------
   // Checks
   // --------------------------------------------------
   a_read_data: assert property (
      @(posedge clk) disable iff (rst) (ack && chk_on) |-> dat_r == chk_exp
   ) else stop_on_error($sformatf("** Error %s: expected %h, actual %h",
                                  chk_name, chk_exp, dat_r));

   // One ack per access, in the cycle after strobe
   a_ack_once: assert property (
      @(posedge clk) disable iff (rst) $rose(cyc && stb) |=> ack ##1 !ack
   ) else stop_on_error("Access was not acked exactly once one cycle after strobe");

   a_ack_live: assert property (
      @(posedge clk) disable iff (rst) ack |-> cyc && stb
   ) else stop_on_error("Ack came while no strobe was pending");

   // --------------------------------------------------
   // Stimulus
   // --------------------------------------------------
   initial begin
      int          idx;
      logic [31:0] wdata;
      logic [23:0] x;
      logic [23:0] y;
      logic [15:0] u;
      idx = 0;
      repeat (RST_CYCLES) @(posedge clk);
      rst <= 1'b0;

      // Nothing looked up yet
      check_reg(lut_pkg::ADDR_STATUS, 32'h0, "reset_status");
      check_reg(lut_pkg::ADDR_X, 32'h0, "reset_x");
      check_reg(lut_pkg::ADDR_Y, 32'h0, "reset_y");
      check_reg(lut_pkg::ADDR_UV, 32'h0, "reset_uv");
      check_reg(lut_pkg::ADDR_INT, 32'h0, "reset_int");

      // Full table sweep
      for (int i = 0; i < lut_pkg::NIDX; i++) begin
         x = x_of(i);
         y = -x;
         write_reg(lut_pkg::ADDR_INDEX, 32'(i));
         // Lookup still in flight
         check_reg(lut_pkg::ADDR_STATUS, 32'h0, "ready_clear");
         wait_ready();
         check_reg(lut_pkg::ADDR_X, {{8{x[23]}}, x}, "sweep_x");
         check_reg(lut_pkg::ADDR_Y, {{8{y[23]}}, y}, "sweep_y");
         // Top 8 bits of each, integer view
         check_reg(lut_pkg::ADDR_INT, {16'h0, x[23:16], y[23:16]}, "sweep_int");
      end

      // Random indices, junk above the index bits
      for (int n = 0; n < N_RAND; n++) begin
         wdata = $random(seed);
         idx = int'(wdata[3:0]);
         u = u_of(idx);
         write_reg(lut_pkg::ADDR_INDEX, wdata);
         wait_ready();
         check_reg(lut_pkg::ADDR_UV, {u, ~u}, "rand_uv");
      end

      // Read-only registers drop writes
      x = x_of(idx);
      y = -x;
      u = u_of(idx);
      write_reg(lut_pkg::ADDR_X, 32'hdead_beef);
      write_reg(lut_pkg::ADDR_STATUS, 32'h0);
      write_reg(lut_pkg::ADDR_UV, 32'h1234_5678);
      write_reg(lut_pkg::ADDR_INT, 32'hffff_ffff);
      check_reg(lut_pkg::ADDR_X, {{8{x[23]}}, x}, "ro_x");
      check_reg(lut_pkg::ADDR_Y, {{8{y[23]}}, y}, "ro_y");
      check_reg(lut_pkg::ADDR_UV, {u, ~u}, "ro_uv");
      check_reg(lut_pkg::ADDR_STATUS, 32'h1, "ro_status");

      $display("test passed");
      $finish;
   end

endmodule

/* logic/lut_top.sv */
// Coefficient lookup subsystem top
`timescale 1ns/10ps

module lut_top (
   input  logic                        clk,
   input  logic                        rst,
   // Wishbone classic
   input  logic                        cyc,
   input  logic                        stb,
   input  logic                        we,
   input  logic [2:0]                  adr,
   input  logic [lut_pkg::BUS_DW-1:0]  dat_w,
   output logic [lut_pkg::BUS_DW-1:0]  dat_r,
   output logic                        ack
);

   // --------------------------------------------------
   // Pipeline links
   // --------------------------------------------------
   logic [lut_pkg::IW-1:0]  index;
   logic                    index_load;
   lut_pkg::lut_entry_t     entry;
   logic                    entry_valid;
   lut_pkg::lut_result_t    result;
   logic                    result_valid;

   // Bus registers and status
   lut_wb_slave u_wb_slave (
      .clk          (clk),
      .rst          (rst),
      .cyc          (cyc),
      .stb          (stb),
      .we           (we),
      .adr          (adr),
      .dat_w        (dat_w),
      .dat_r        (dat_r),
      .ack          (ack),
      .index        (index),
      .index_load   (index_load),
      .result       (result),
      .result_valid (result_valid)
   );

   // Table fetch, one cycle
   lut_decoder u_decoder (
      .clk          (clk),
      .rst          (rst),
      .index        (index),
      .index_load   (index_load),
      .entry        (entry),
      .entry_valid  (entry_valid)
   );

   // CSD conversion and field split, one cycle
   lut_result_unpack u_result_unpack (
      .clk          (clk),
      .rst          (rst),
      .entry        (entry),
      .entry_valid  (entry_valid),
      .result       (result),
      .result_valid (result_valid)
   );

endmodule

/* logic/lut_wb_slave.sv */
// Wishbone classic register slave
`timescale 1ns/10ps

module lut_wb_slave (
   input  logic                           clk,
   input  logic                           rst,
   // Wishbone classic
   input  logic                           cyc,
   input  logic                           stb,
   input  logic                           we,
   input  logic [2:0]                     adr,
   input  logic [lut_pkg::BUS_DW-1:0]     dat_w,
   output logic [lut_pkg::BUS_DW-1:0]     dat_r,
   output logic                           ack,
   // Lookup request
   output logic [lut_pkg::IW-1:0]         index,
   output logic                           index_load,
   // Unpacked result
   input  lut_pkg::lut_result_t           result,
   input  logic                           result_valid
);

   // New access with strobe seen and not yet acked
   logic                        access;
   // Index write in its strobe cycle
   logic                        wr_index;
   // Status flag
   logic                        ready;
   logic [lut_pkg::BUS_DW-1:0]  rd_data;

   assign access   = cyc && stb && !ack;
   assign wr_index = access && we && (adr == lut_pkg::ADDR_INDEX);

   // --------------------------------------------------
   // Handshake and control
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         ack        <= 1'b0;
         index_load <= 1'b0;
         ready      <= 1'b0;
      end else begin
         // Single-cycle ack one cycle after strobe
         ack        <= access;
         // Load pulse lines up with the write ack
         index_load <= wr_index;
         // Index write wins over a finishing lookup
         if (wr_index) begin
            ready <= 1'b0;
         end else if (result_valid && !index_load) begin
            // Only the newest lookup sets ready
            ready <= 1'b1;
         end
      end
   end

   // --------------------------------------------------
   // Read multiplexer
   // --------------------------------------------------
   always_comb begin
      case (adr)
         lut_pkg::ADDR_X: begin
            // Sign extension to the bus width
            rd_data = {{(lut_pkg::BUS_DW-lut_pkg::WD){result.x.raw[lut_pkg::WD-1]}},
                       result.x.raw};
         end
         lut_pkg::ADDR_Y: begin
            rd_data = {{(lut_pkg::BUS_DW-lut_pkg::WD){result.y.raw[lut_pkg::WD-1]}},
                       result.y.raw};
         end
         lut_pkg::ADDR_UV: begin
            rd_data = {result.u.raw, result.v.raw};
         end
         lut_pkg::ADDR_INT: begin
            // Integer view of X and Y
            rd_data = {{(lut_pkg::BUS_DW-2*lut_pkg::WI){1'b0}},
                       result.x.f.int_part, result.y.f.int_part};
         end
         lut_pkg::ADDR_STATUS: begin
            rd_data = {{(lut_pkg::BUS_DW-1){1'b0}}, ready};
         end
         default: begin
            // Write-only index and spare addresses read zero
            rd_data = '0;
         end
      endcase
   end

   // --------------------------------------------------
   // Data registers
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      // Writes elsewhere are acked and dropped
      if (wr_index) begin
         index <= dat_w[lut_pkg::IW-1:0];
      end
      // Read data valid in the ack cycle
      if (access && !we) begin
         dat_r <= rd_data;
      end
   end

   // --------------------------------------------------
   // Checks
   // --------------------------------------------------
   // Ack rises only for a live strobe held from the cycle before
   a_ack_cause: assert property (
      @(posedge clk) disable iff (rst) $rose(ack) |-> cyc && stb && $past(cyc && stb)
   );

   // Never two acks in a row
   a_ack_single: assert property (
      @(posedge clk) disable iff (rst) ack |=> !ack
   );

endmodule

/* logic/lut_result_unpack.sv */
// CSD to fixed-point result unpacker
`timescale 1ns/10ps

module lut_result_unpack (
   input  logic                  clk,
   input  logic                  rst,
   input  lut_pkg::lut_entry_t   entry,
   input  logic                  entry_valid,
   output lut_pkg::lut_result_t  result,
   output logic                  result_valid
);

   // --------------------------------------------------
   // CSD to binary
   // --------------------------------------------------
   logic [lut_pkg::WD-1:0] x_bin;
   logic [lut_pkg::WD-1:0] y_bin;
   // Next result built field by field
   lut_pkg::lut_result_t   res_d;

   // Positive digits minus negative digits modulo 2^WD
   assign x_bin = entry.x.pos - entry.x.neg;
   assign y_bin = entry.y.pos - entry.y.neg;

   // --------------------------------------------------
   // Integer and fraction split
   // --------------------------------------------------
   always_comb begin
      // Top WI bits are the signed integer part
      res_d.x.f.int_part = x_bin[lut_pkg::WD-1 -: lut_pkg::WI];
      res_d.x.f.frac     = x_bin[lut_pkg::WD-lut_pkg::WI-1:0];
      res_d.y.f.int_part = y_bin[lut_pkg::WD-1 -: lut_pkg::WI];
      res_d.y.f.frac     = y_bin[lut_pkg::WD-lut_pkg::WI-1:0];
      // u and v are already binary
      res_d.u.f.int_part = entry.u[lut_pkg::WC-1 -: lut_pkg::WI];
      res_d.u.f.frac     = entry.u[lut_pkg::WC-lut_pkg::WI-1:0];
      res_d.v.f.int_part = entry.v[lut_pkg::WC-1 -: lut_pkg::WI];
      res_d.v.f.frac     = entry.v[lut_pkg::WC-lut_pkg::WI-1:0];
   end

   // --------------------------------------------------
   // Result register
   // --------------------------------------------------
   // Last lookup result and its valid strobe
   always_ff @(posedge clk) begin
      if (rst) begin
         result       <= '0;
         result_valid <= 1'b0;
      end else begin
         result_valid <= entry_valid;
         if (entry_valid) begin
            result <= res_d;
         end
      end
   end

   // --------------------------------------------------
   // Checks
   // --------------------------------------------------
   // Every entry produces a result on the next cycle
   a_valid_follows: assert property (
      @(posedge clk) disable iff (rst) entry_valid |=> result_valid
   );

   // No result without an entry one cycle earlier
   a_valid_cause: assert property (
      @(posedge clk) disable iff (rst) result_valid |-> $past(entry_valid)
   );

endmodule

/* logic/lut_decoder.sv */
// Coefficient table lookup
`timescale 1ns/10ps

module lut_decoder (
   input  logic                      clk,
   input  logic                      rst,
   input  logic [lut_pkg::IW-1:0]    index,
   input  logic                      index_load,
   output lut_pkg::lut_entry_t       entry,
   output logic                      entry_valid
);

   // --------------------------------------------------
   // Constant table
   // --------------------------------------------------
   // One entry per index, X and Y already in CSD
   lut_pkg::lut_entry_t lut_rom [lut_pkg::NIDX];

   // Digit rules of a canonical word
   function automatic logic csd_ok(input lut_pkg::lut_csd_t c);
      logic [lut_pkg::WD-1:0] nz;
      nz = c.pos | c.neg;
      // No digit both +1 and -1, no two nonzero neighbours
      return ((c.pos & c.neg) == '0) && ((nz & (nz >> 1)) == '0);
   endfunction

   for (genvar g = 0; g < lut_pkg::NIDX; g++) begin : g_rom
      // Folded to constants at elaboration
      assign lut_rom[g].x = lut_pkg::csd_encode(lut_pkg::lut_rule_x(lut_pkg::IW'(g)));
      assign lut_rom[g].y = lut_pkg::csd_encode(lut_pkg::lut_rule_y(lut_pkg::IW'(g)));
      assign lut_rom[g].u = lut_pkg::lut_rule_u(lut_pkg::IW'(g));
      assign lut_rom[g].v = lut_pkg::lut_rule_v(lut_pkg::IW'(g));

      // Encoder output must stay in non-adjacent form
      a_csd_form: assert property (
         @(posedge clk) csd_ok(lut_rom[g].x) && csd_ok(lut_rom[g].y)
      );
   end

   // --------------------------------------------------
   // Output register
   // --------------------------------------------------
   // Valid strobe, one cycle behind the load
   always_ff @(posedge clk) begin
      if (rst) begin
         entry_valid <= 1'b0;
      end else begin
         entry_valid <= index_load;
      end
   end

   // Entry payload
   always_ff @(posedge clk) begin
      if (index_load) begin
         entry <= lut_rom[index];
      end
   end

endmodule

/* logic/lut_pkg.sv */
// Coefficient lookup shared definitions
package lut_pkg;

   // --------------------------------------------------
   // Widths
   // --------------------------------------------------
   // Binary X and Y width
   localparam int WD = 24;
   // Binary u and v width
   localparam int WC = 16;
   // Integer bits of every coefficient
   localparam int WI = 8;
   // Table depth and index width
   localparam int NIDX = 16;
   localparam int IW = 4;
   // Bus data width
   localparam int BUS_DW = 32;

   // --------------------------------------------------
   // Bus address map, word addresses
   // --------------------------------------------------
   localparam logic [2:0] ADDR_INDEX  = 3'd0;
   localparam logic [2:0] ADDR_X      = 3'd1;
   localparam logic [2:0] ADDR_Y      = 3'd2;
   localparam logic [2:0] ADDR_UV     = 3'd3;
   localparam logic [2:0] ADDR_INT    = 3'd4;
   localparam logic [2:0] ADDR_STATUS = 3'd5;

   // --------------------------------------------------
   // Types
   // --------------------------------------------------
   // One pos and one neg bit per digit
   typedef struct packed {
      logic [WD-1:0] pos;
      logic [WD-1:0] neg;
   } lut_csd_t;

   // Lookup output, 128 bits
   typedef struct packed {
      lut_csd_t      x;
      lut_csd_t      y;
      logic [WC-1:0] u;
      logic [WC-1:0] v;
   } lut_entry_t;

   // Fixed-point fields, integer part on top
   typedef struct packed {
      logic signed [WI-1:0] int_part;
      logic [WD-WI-1:0]     frac;
   } fix_wd_s;

   typedef struct packed {
      logic signed [WI-1:0] int_part;
      logic [WC-WI-1:0]     frac;
   } fix_wc_s;

   // Same word seen as raw bits or as fields
   typedef union packed {
      logic [WD-1:0] raw;
      fix_wd_s       f;
   } fix_wd_u;

   typedef union packed {
      logic [WC-1:0] raw;
      fix_wc_s       f;
   } fix_wc_u;

   // Unpacker output bundle
   typedef struct packed {
      fix_wd_u x;
      fix_wd_u y;
      fix_wc_u u;
      fix_wc_u v;
   } lut_result_t;

   // --------------------------------------------------
   // Table rule
   // --------------------------------------------------
   // X(i) = i*4096 + i*341, wrapped
   function automatic logic [WD-1:0] lut_rule_x(input logic [IW-1:0] i);
      int v;
      v = int'(i) * 4096 + int'(i) * 341;
      return WD'(v);
   endfunction

   // Y is the negation of X
   function automatic logic [WD-1:0] lut_rule_y(input logic [IW-1:0] i);
      return -lut_rule_x(i);
   endfunction

   // u(i) = i*291, wrapped
   function automatic logic [WC-1:0] lut_rule_u(input logic [IW-1:0] i);
      int v;
      v = int'(i) * 291;
      return WC'(v);
   endfunction

   // v is the bitwise inverse of u
   function automatic logic [WC-1:0] lut_rule_v(input logic [IW-1:0] i);
      return ~lut_rule_u(i);
   endfunction

   // Non-adjacent form of a two's-complement word
   function automatic lut_csd_t csd_encode(input logic [WD-1:0] bin);
      logic signed [WD+1:0] k;
      lut_csd_t             c;
      k = signed'(bin);
      c = '0;
      for (int n = 0; n < WD; n++) begin
         // Odd remainder picks +1 or -1 so the next digit is zero
         if (k[0]) begin
            if (k[1]) begin
               c.neg[n] = 1'b1;
               k = k + 1;
            end else begin
               c.pos[n] = 1'b1;
               k = k - 1;
            end
         end
         k = k >>> 1;
      end
      return c;
   endfunction

endpackage
